/* numericPkg.sv */
package numericPkg;

	// input features arrive as raw unsigned bytes.
	typedef logic [7:0] featureT;

	// weights are two's complement, one byte per neuron.
	typedef logic signed [7:0] weightT;

	// 187 products of 255 * -128 still fit in 24 bits signed.
	typedef logic signed [23:0] accT;

	// activations leave the layer as unsigned bytes.
	typedef logic [7:0] actT;

	localparam actT ActMax = '1; // saturation ceiling of an activation.

endpackage

/* layerPkg.sv */
package layerPkg;

	import numericPkg::*;

	localparam int NumNeurons = 5;
	localparam int MaxInputs = 256; // the index type must cover any vector length up to this.

	typedef logic [$clog2(MaxInputs)-1:0] inputIdxT;

	// one entry of the weight memory holds a weight for every neuron.
	typedef weightT [NumNeurons-1:0] weightVecT;
	typedef accT [NumNeurons-1:0] accVecT;
	typedef actT [NumNeurons-1:0] actVecT;

	typedef struct packed {
		featureT feature;
		inputIdxT idx;
		logic first; // index zero of a vector.
		logic last;  // index NumInputs-1 of a vector.
	} featBeatT;

endpackage

/* pipeStage.sv */
`timescale 1ns/10ps

module pipeStage #(
	parameter type PayloadT = logic
) (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input PayloadT inData,
	output logic outValid,
	input logic outReady,
	output PayloadT outData
);

	// the slot takes a new item when empty or when its current item leaves.
	assign inReady = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			outData <= inData;
		end
	end

endmodule

/* featureSequencer.sv */
`timescale 1ns/10ps

module featureSequencer
	import numericPkg::*, layerPkg::*;
#(
	parameter int NumInputs = 187
) (
	input logic clk,
	input logic rst,
	input logic featValid,
	output logic featReady,
	input featureT featData,
	output logic beatValid,
	input logic beatReady,
	output featBeatT beat
);

	inputIdxT idx;
	logic lastIdx;
	featBeatT nextBeat;

	assign lastIdx = (idx == inputIdxT'(NumInputs - 1));

	assign nextBeat = '{
		feature: featData,
		idx: idx,
		first: (idx == '0),
		last: lastIdx
	};

	// the counter only moves on an accepted feature and wraps at the vector end.
	always_ff @(posedge clk) begin
		if (rst) begin
			idx <= '0;
		end else if (featValid && featReady) begin
			idx <= lastIdx ? '0 : idx + 1'b1;
		end
	end

	pipeStage #(.PayloadT(featBeatT)) u_beatStage (
		.clk(clk),
		.rst(rst),
		.inValid(featValid),
		.inReady(featReady),
		.inData(nextBeat),
		.outValid(beatValid),
		.outReady(beatReady),
		.outData(beat)
	);

endmodule

/* weightMem.sv */
`timescale 1ns/10ps

module weightMem
	import numericPkg::*, layerPkg::*;
#(
	parameter int NumInputs = 187
) (
	input logic clk,
	input logic rst,
	input logic weightWe,
	input inputIdxT weightAddr,
	input weightVecT weightData,
	input logic beatValid,
	output logic beatReady,
	input featBeatT beat,
	output logic termValid,
	input logic termReady,
	output featureT termFeature,
	output weightVecT termWeights,
	output logic termFirst,
	output logic termLast
);

	weightVecT mem [0:NumInputs-1];

	assign beatReady = !termValid || termReady;

	always_ff @(posedge clk) begin
		if (weightWe) begin
			mem[weightAddr] <= weightData;
		end
	end

	// the read register keeps its word while the next stage stalls.
	always_ff @(posedge clk) begin
		if (beatValid && beatReady) begin
			termWeights <= mem[beat.idx];
			termFeature <= beat.feature; // feature and flags stay aligned with the read.
			termFirst <= beat.first;
			termLast <= beat.last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			termValid <= 1'b0;
		end else if (beatReady) begin
			termValid <= beatValid;
		end
	end

endmodule

/* macArray.sv */
`timescale 1ns/10ps

module macArray
	import numericPkg::*, layerPkg::*;
(
	input logic clk,
	input logic rst,
	input logic termValid,
	output logic termReady,
	input featureT termFeature,
	input weightVecT termWeights,
	input logic termFirst,
	input logic termLast,
	output logic sumValid,
	input logic sumReady,
	output accVecT sums
);

	accVecT prod;
	accVecT acc;
	accVecT accNext;
	logic prodValid;
	logic prodFirst;
	logic prodLast;
	logic prodDrain;

	// a product that closes a vector waits until the result register is free.
	assign prodDrain = prodValid && (!prodLast || !sumValid || sumReady);
	assign termReady = !prodValid || prodDrain;

	always_comb begin
		for (int n = 0; n < NumNeurons; n++) begin
			accNext[n] = prodFirst ? prod[n] : acc[n] + prod[n];
		end
	end

	always_ff @(posedge clk) begin
		if (termValid && termReady) begin
			for (int n = 0; n < NumNeurons; n++) begin
				prod[n] <= accT'($signed({1'b0, termFeature})) * accT'(termWeights[n]);
			end
			prodFirst <= termFirst;
			prodLast <= termLast;
		end
		if (prodDrain) begin
			acc <= accNext;
		end
		if (prodDrain && prodLast) begin
			sums <= accNext; // acc is free for the next vector from here on.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prodValid <= 1'b0;
			sumValid <= 1'b0;
		end else begin
			if (termReady) begin
				prodValid <= termValid;
			end
			if (prodDrain && prodLast) begin
				sumValid <= 1'b1;
			end else if (sumReady) begin
				sumValid <= 1'b0;
			end
		end
	end

endmodule

/* activationStage.sv */
`timescale 1ns/10ps

module activationStage
	import numericPkg::*, layerPkg::*;
#(
	parameter int ShiftBits = 7
) (
	input logic clk,
	input logic rst,
	input logic sumValid,
	output logic sumReady,
	input accVecT sums,
	output logic outValid,
	input logic outReady,
	output actVecT outData
);

	actVecT act;

	always_comb begin
		accT shifted;
		for (int n = 0; n < NumNeurons; n++) begin
			shifted = sums[n] >>> ShiftBits;
			if (sums[n][$bits(accT)-1]) begin
				act[n] = '0; // negative sums are cut off before scaling.
			end else if (shifted > accT'(ActMax)) begin
				act[n] = ActMax;
			end else begin
				act[n] = shifted[$bits(actT)-1:0];
			end
		end
	end

	pipeStage #(.PayloadT(actVecT)) u_outStage (
		.clk(clk),
		.rst(rst),
		.inValid(sumValid),
		.inReady(sumReady),
		.inData(act),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

endmodule

/* denseLayer.sv */
`timescale 1ns/10ps

module denseLayer
	import numericPkg::*, layerPkg::*;
#(
	parameter int NumInputs = 187,
	parameter int ShiftBits = 7
) (
	input logic clk,
	input logic rst,
	input logic featValid,
	output logic featReady,
	input featureT featData,
	input logic weightWe,
	input inputIdxT weightAddr,
	input weightVecT weightData,
	output logic outValid,
	input logic outReady,
	output actVecT outData
);

	logic beatValid;
	logic beatReady;
	featBeatT beat;
	logic termValid;
	logic termReady;
	featureT termFeature;
	weightVecT termWeights;
	logic termFirst;
	logic termLast;
	logic sumValid;
	logic sumReady;
	accVecT sums;

	featureSequencer #(.NumInputs(NumInputs)) u_featureSequencer (
		.clk(clk),
		.rst(rst),
		.featValid(featValid),
		.featReady(featReady),
		.featData(featData),
		.beatValid(beatValid),
		.beatReady(beatReady),
		.beat(beat)
	);

	weightMem #(.NumInputs(NumInputs)) u_weightMem (
		.clk(clk),
		.rst(rst),
		.weightWe(weightWe),
		.weightAddr(weightAddr),
		.weightData(weightData),
		.beatValid(beatValid),
		.beatReady(beatReady),
		.beat(beat),
		.termValid(termValid),
		.termReady(termReady),
		.termFeature(termFeature),
		.termWeights(termWeights),
		.termFirst(termFirst),
		.termLast(termLast)
	);

	macArray u_macArray (
		.clk(clk),
		.rst(rst),
		.termValid(termValid),
		.termReady(termReady),
		.termFeature(termFeature),
		.termWeights(termWeights),
		.termFirst(termFirst),
		.termLast(termLast),
		.sumValid(sumValid),
		.sumReady(sumReady),
		.sums(sums)
	);

	activationStage #(.ShiftBits(ShiftBits)) u_activationStage (
		.clk(clk),
		.rst(rst),
		.sumValid(sumValid),
		.sumReady(sumReady),
		.sums(sums),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

endmodule

/* denseLayer_props.sv */
`timescale 1ns/10ps

module denseLayerProps
	import layerPkg::*;
(
	input logic clk,
	input logic rst,
	input logic featReady,
	input logic beatValid,
	input logic outValid,
	input logic outReady,
	input actVecT outData
);

	// reset must leave the output stream empty.
	assert property (@(posedge clk) rst |=> !outValid)
		else $error("outValid is high in the cycle after reset");

	assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("outData or outValid changed while the result stream was stalled");

	// the input side only blocks while the beat register is full and the output is stalled.
	assert property (@(posedge clk) disable iff (rst)
		!featReady |-> beatValid && outValid && !outReady)
		else $error("featReady is low while the first stage is empty or the output is free");

endmodule

bind denseLayer denseLayerProps u_denseLayerProps (.*);

/* denseLayerTb.sv */
`timescale 1ns/10ps

module denseLayerTb
	import numericPkg::*, layerPkg::*;
();

	localparam int NumInputs = 187;
	localparam int RefShift = 7;
	localparam int MaxVecs = 3;
	localparam int NumRows = 7;
	localparam int BeatTimeout = 1000;
	localparam int ResultTimeout = 4000;

	// fMode 0 is a constant feature, 1 is random and 2 reuses the previous row's features.
	typedef struct packed {
		logic wRand;
		weightT wConst;
		logic [1:0] fMode;
		featureT fConst;
		logic stallRand;
		int nVec;
		actVecT expected;
	} stimRowT;

	stimRowT stimTable [NumRows] = '{
		'{1'b0, 8'sd1, 2'd0, 8'd1, 1'b0, 1, {5{8'h01}}},
		'{1'b0, -8'sd1, 2'd0, 8'd1, 1'b0, 1, {5{8'h00}}},
		'{1'b0, 8'sd127, 2'd0, 8'd255, 1'b0, 1, {5{8'hff}}},
		'{1'b1, 8'sd0, 2'd1, 8'd0, 1'b0, 1, {5{8'h00}}},
		'{1'b1, 8'sd0, 2'd1, 8'd0, 1'b1, 3, {5{8'h00}}},
		'{1'b1, 8'sd0, 2'd1, 8'd0, 1'b0, 1, {5{8'h00}}},
		'{1'b1, 8'sd0, 2'd2, 8'd0, 1'b1, 1, {5{8'h00}}}
	};

	logic clk;
	logic rst;
	logic featValid;
	logic featReady;
	featureT featData;
	logic weightWe;
	inputIdxT weightAddr;
	weightVecT weightData;
	logic outValid;
	logic outReady;
	actVecT outData;

	integer seed;
	int valueErrors;
	int timeoutErrors;
	featureT feats [MaxVecs][NumInputs];
	weightVecT wts [NumInputs];
	actVecT expQ [$];

	denseLayer u_denseLayer (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic checkActVec(input string name, input actVecT got, input actVecT exp);
		if (got !== exp) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			valueErrors++;
		end
	endtask

	// expected activation from the layer rule: sum, rectify, shift, saturate.
	function automatic actT refNeuron(input int v, input int n);
		int sum;
		sum = 0;
		for (int i = 0; i < NumInputs; i++) begin
			sum += int'(feats[v][i]) * int'(wts[i][n]);
		end
		if (sum < 0) sum = 0;
		sum = sum >>> RefShift;
		if (sum > 255) return 8'hff;
		return actT'(sum);
	endfunction

	function automatic actVecT refVector(input int v);
		actVecT vec;
		for (int n = 0; n < NumNeurons; n++) vec[n] = refNeuron(v, n);
		return vec;
	endfunction

	task automatic writeWeights(input stimRowT row);
		for (int i = 0; i < NumInputs; i++) begin
			for (int n = 0; n < NumNeurons; n++) begin
				wts[i][n] = row.wRand ? weightT'($random(seed)) : row.wConst;
			end
			weightWe = 1'b1;
			weightAddr = inputIdxT'(i);
			weightData = wts[i];
			@(negedge clk);
		end
		weightWe = 1'b0;
	endtask

	task automatic sendVectors(input int count);
		int waited;
		logic accepted;
		for (int v = 0; v < count; v++) begin
			for (int i = 0; i < NumInputs; i++) begin
				if (($random(seed) & 3) == 0) begin
					featValid = 1'b0; // idle gap in the stream.
					@(negedge clk);
				end
				featValid = 1'b1;
				featData = feats[v][i];
				waited = 0;
				accepted = 1'b0;
				while (!accepted && waited < BeatTimeout) begin
					@(posedge clk);
					accepted = featReady; // the beat transfers on this edge when ready is high.
					waited++;
				end
				if (!accepted) begin
					$display("timeout: featReady stayed low for feature %0d of vector %0d", i, v);
					timeoutErrors++;
				end
				@(negedge clk);
			end
		end
		featValid = 1'b0;
	endtask

	task automatic collectResults(input int count, input logic stallRand);
		actVecT held;
		logic holding;
		logic done;
		int waited;
		holding = 1'b0;
		held = '0;
		for (int r = 0; r < count; r++) begin
			waited = 0;
			done = 1'b0;
			while (!done && waited < ResultTimeout) begin
				@(negedge clk);
				if (holding) begin
					checkBit("outValid", outValid, 1'b1); // a stalled result must stay.
					checkActVec("outData", outData, held);
				end
				outReady = stallRand ? 1'($random(seed)) : 1'b1;
				holding = outValid && !outReady;
				held = outData;
				if (outValid && outReady) begin
					checkActVec("outData", outData, expQ.pop_front());
					done = 1'b1;
				end
				waited++;
			end
			if (!done) begin
				$display("timeout: result %0d of the row never arrived", r);
				timeoutErrors++;
			end
		end
		@(negedge clk);
		outReady = 1'b0;
	endtask

	task automatic runRow(input stimRowT row);
		for (int v = 0; v < row.nVec; v++) begin
			for (int i = 0; i < NumInputs; i++) begin
				if (row.fMode == 2'd0) feats[v][i] = row.fConst;
				else if (row.fMode == 2'd1) feats[v][i] = featureT'($random(seed));
			end
		end
		writeWeights(row);
		for (int v = 0; v < row.nVec; v++) begin
			if (!row.wRand && row.fMode == 2'd0) expQ.push_back(row.expected);
			else expQ.push_back(refVector(v));
		end
		fork
			sendVectors(row.nVec);
			collectResults(row.nVec, row.stallRand);
		join
		repeat (4) @(negedge clk);
		checkBit("outValid", outValid, 1'b0); // nothing extra may follow the last result.
		checkBit("featReady", featReady, 1'b1);
	endtask

	initial begin
		seed = 11153;
		rst = 1'b1;
		featValid = 1'b0;
		featData = '0;
		weightWe = 1'b0;
		weightAddr = '0;
		weightData = '0;
		outReady = 1'b0;
		valueErrors = 0;
		timeoutErrors = 0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		checkBit("outValid", outValid, 1'b0);
		checkBit("featReady", featReady, 1'b1);
		for (int r = 0; r < NumRows; r++) runRow(stimTable[r]);
		$display("value errors: %0d, timeout errors: %0d", valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
numericPkg.sv
layerPkg.sv
pipeStage.sv
featureSequencer.sv
weightMem.sv
macArray.sv
activationStage.sv
denseLayer.sv
denseLayer_props.sv
denseLayerTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the denseLayer testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module denseLayerTb \
	-f project.f

./obj_dir/VdenseLayerTb > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0
